//--- zynq_bridge_pkg.sv
`default_nettype none

package zynq_bridge_pkg;

   // host, device and host DRAM addresses all share one width
   localparam int unsigned ADDR_W = 32;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned STRB_W = DATA_W / 8;

   // cached DRAM starts here in the device address map
   localparam logic [ADDR_W-1:0] DEV_DRAM_BASE = 32'h8000_0000;

   // host window split on the second slave port
   // addresses above the split reach device-local space and lose the split bit
   // addresses at or below it land in cached DRAM and gain the top bit
   localparam logic [ADDR_W-1:0] HOST_WINDOW_SPLIT = 32'h2000_0000;

   // device DRAM offsets at or above this are outside the host allocation
   localparam logic [ADDR_W-1:0] MEM_UPPER_LIMIT = 120 * 1024 * 1024;

   // one profiler bit per 8 MiB region of device memory
   localparam int unsigned PROFILE_REGIONS = 128;
   localparam int unsigned PROFILE_IDX_W = $clog2(PROFILE_REGIONS);
   // region index is device address bits 29 down to 23
   localparam int unsigned PROFILE_LSB = 23;

   localparam int unsigned CSR_ADDR_W = 4;
   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

   // writable registers
   localparam csr_addr_t CSR_CTRL = 4'd0;
   localparam csr_addr_t CSR_DRAM_ALLOC = 4'd1;
   localparam csr_addr_t CSR_DRAM_BASE = 4'd2;
   // bit zero is the sticky over-limit flag and is cleared by writing one
   localparam csr_addr_t CSR_STATUS = 4'd3;
   // read-only counters and profiler words
   localparam csr_addr_t CSR_REQ_COUNT = 4'd4;
   localparam csr_addr_t CSR_PROFILE0 = 4'd5;
   localparam csr_addr_t CSR_PROFILE1 = 4'd6;
   localparam csr_addr_t CSR_PROFILE2 = 4'd7;
   localparam csr_addr_t CSR_PROFILE3 = 4'd8;

   // host write request as it enters through the second slave port
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
   } host_wr_req_t;

   // host read request carries only its address
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
   } host_rd_req_t;

endpackage

`default_nettype wire

//--- mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// remapped DRAM request leaving the bridge towards host memory
interface mem_req_if;
   import zynq_bridge_pkg::*;

   logic valid;
   logic ready;
   // address already moved into host DRAM space
   logic [ADDR_W-1:0] addr;
   // original device address, kept for the profiler
   logic [ADDR_W-1:0] dev_addr;
   logic we;

   // the remap stage owns the request side
   modport source (
      output valid,
      output addr,
      output dev_addr,
      output we,
      input ready
   );

   // passive observer that only counts transfers
   modport monitor (
      input valid,
      input ready,
      input addr,
      input dev_addr,
      input we
   );

endinterface

`default_nettype wire

//--- csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regs (
   input wire aclk_i,
   input wire arst_n_i,
   input wire csr_we_i,
   input wire zynq_bridge_pkg::csr_addr_t csr_waddr_i,
   input wire [zynq_bridge_pkg::DATA_W-1:0] csr_wdata_i,
   input wire csr_re_i,
   input wire zynq_bridge_pkg::csr_addr_t csr_raddr_i,
   output logic [zynq_bridge_pkg::DATA_W-1:0] csr_rdata_o,
   output logic csr_rvalid_o,
   input wire over_limit_i,
   input wire [zynq_bridge_pkg::PROFILE_REGIONS-1:0] profile_i,
   input wire [zynq_bridge_pkg::DATA_W-1:0] req_count_i,
   output logic [zynq_bridge_pkg::ADDR_W-1:0] dram_base_o,
   output logic dram_alloc_o,
   output logic dev_reset_o
);
   import zynq_bridge_pkg::*;

   logic [DATA_W-1:0] ctrl_q;
   logic alloc_q;
   logic [ADDR_W-1:0] base_q;
   logic status_q;
   logic [DATA_W-1:0] rdata_q;
   logic rvalid_q;
   logic dev_reset_q;
   logic [DATA_W-1:0] rdata_d;

   // software side writes, visible the cycle after the strobe
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ctrl_q <= '0;
         alloc_q <= 1'b0;
         base_q <= '0;
      end
      else if (csr_we_i)
      begin
         case (csr_waddr_i)
            CSR_CTRL: ctrl_q <= csr_wdata_i;
            CSR_DRAM_ALLOC: alloc_q <= csr_wdata_i[0];
            CSR_DRAM_BASE: base_q <= ADDR_W'(csr_wdata_i);
            default: ;
         endcase
      end
   end

   // sticky over-limit flag
   // a new pulse wins over a clear in the same cycle so no event is lost
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         status_q <= 1'b0;
      else if (over_limit_i)
         status_q <= 1'b1;
      else if (csr_we_i && csr_waddr_i == CSR_STATUS && csr_wdata_i[0])
         status_q <= 1'b0;
   end

   // device stays in reset until software sets the run bit
   // clearing it again restarts the device without a bitstream reload
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         dev_reset_q <= 1'b1;
      else
         dev_reset_q <= ~ctrl_q[0];
   end

   // read mux picks stored registers or live counters by index
   always_comb
   begin
      rdata_d = '0;
      case (csr_raddr_i)
         CSR_CTRL: rdata_d = ctrl_q;
         CSR_DRAM_ALLOC: rdata_d = DATA_W'(alloc_q);
         CSR_DRAM_BASE: rdata_d = DATA_W'(base_q);
         CSR_STATUS: rdata_d = DATA_W'(status_q);
         CSR_REQ_COUNT: rdata_d = req_count_i;
         CSR_PROFILE0: rdata_d = profile_i[0*DATA_W +: DATA_W];
         CSR_PROFILE1: rdata_d = profile_i[1*DATA_W +: DATA_W];
         CSR_PROFILE2: rdata_d = profile_i[2*DATA_W +: DATA_W];
         CSR_PROFILE3: rdata_d = profile_i[3*DATA_W +: DATA_W];
         default: rdata_d = '0;
      endcase
   end

   // read data returns one cycle after the read strobe
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rvalid_q <= 1'b0;
         rdata_q <= '0;
      end
      else
      begin
         rvalid_q <= csr_re_i;
         if (csr_re_i)
            rdata_q <= rdata_d;
      end
   end

   assign csr_rdata_o = rdata_q;
   assign csr_rvalid_o = rvalid_q;
   assign dram_base_o = base_q;
   assign dram_alloc_o = alloc_q;
   assign dev_reset_o = dev_reset_q;

   // every read strobe gets exactly one response on the next cycle and no other
   a_rvalid_follows_re: assert property (
      @(posedge aclk_i) disable iff (!arst_n_i)
      csr_re_i |=> csr_rvalid_o
   );
   a_rvalid_only_after_re: assert property (
      @(posedge aclk_i) disable iff (!arst_n_i)
      !csr_re_i |=> !csr_rvalid_o
   );

endmodule

`default_nettype wire

//--- host_addr_xlate.sv
`timescale 1ns/1ps
`default_nettype none

module host_addr_xlate #(
   parameter type req_t = zynq_bridge_pkg::host_rd_req_t
) (
   input wire aclk_i,
   input wire arst_n_i,
   input wire in_valid_i,
   output logic in_ready_o,
   input wire req_t in_req_i,
   output logic out_valid_o,
   input wire out_ready_i,
   output req_t out_req_o
);
   import zynq_bridge_pkg::*;

   logic out_valid_q;
   req_t out_req_q;
   req_t xlate_req;
   logic [ADDR_W-1:0] win_offset;

   // window rule on the host address
   // the upper window maps to device-local space by dropping the split bit
   // everything else is cached DRAM so the top bit is set
   always_comb
   begin
      xlate_req = in_req_i;
      win_offset = DEV_DRAM_BASE;
      if (in_req_i.addr > HOST_WINDOW_SPLIT)
         win_offset = HOST_WINDOW_SPLIT;
      xlate_req.addr = in_req_i.addr ^ win_offset;
   end

   // take a new item when the slot is empty or is being drained this cycle
   assign in_ready_o = ~out_valid_q | out_ready_i;

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         out_valid_q <= 1'b0;
         out_req_q <= '0;
      end
      else if (in_ready_o)
      begin
         out_valid_q <= in_valid_i;
         if (in_valid_i)
            out_req_q <= xlate_req;
      end
   end

   assign out_valid_o = out_valid_q;
   assign out_req_o = out_req_q;

   // a stalled item holds its payload and stays offered
   a_out_stable: assert property (
      @(posedge aclk_i) disable iff (!arst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_req_o)
   );

endmodule

`default_nettype wire

//--- dram_remap.sv
`timescale 1ns/1ps
`default_nettype none

module dram_remap (
   input wire aclk_i,
   input wire arst_n_i,
   input wire dev_reset_i,
   input wire dram_alloc_i,
   input wire [zynq_bridge_pkg::ADDR_W-1:0] dram_base_i,
   input wire in_valid_i,
   output logic in_ready_o,
   input wire [zynq_bridge_pkg::ADDR_W-1:0] in_addr_i,
   input wire in_we_i,
   mem_req_if.source req,
   output logic over_limit_o
);
   import zynq_bridge_pkg::*;

   logic out_valid_q;
   logic [ADDR_W-1:0] addr_q;
   logic [ADDR_W-1:0] dev_addr_q;
   logic we_q;
   logic over_limit_q;
   logic [ADDR_W-1:0] dram_offset;
   logic accept;

   // offset inside device DRAM is the address without its top bit
   assign dram_offset = in_addr_i & ~DEV_DRAM_BASE;

   // nothing enters until host DRAM is allocated and the device is running
   // otherwise the usual rule of an empty or draining slot applies
   assign in_ready_o = dram_alloc_i & ~dev_reset_i & (~out_valid_q | req.ready);
   assign accept = in_valid_i & in_ready_o;

   // control state, flushed by device reset as well as the bridge reset
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         out_valid_q <= 1'b0;
         over_limit_q <= 1'b0;
      end
      else if (dev_reset_i)
      begin
         out_valid_q <= 1'b0;
         over_limit_q <= 1'b0;
      end
      else
      begin
         if (~out_valid_q | req.ready)
            out_valid_q <= accept;
         // one-cycle pulse for each accepted request beyond the allocation
         over_limit_q <= accept && (dram_offset >= MEM_UPPER_LIMIT);
      end
   end

   // remapped address is the offset rebased onto the allocated host DRAM
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         addr_q <= '0;
         dev_addr_q <= '0;
         we_q <= 1'b0;
      end
      else if (accept)
      begin
         addr_q <= dram_offset + dram_base_i;
         dev_addr_q <= in_addr_i;
         we_q <= in_we_i;
      end
   end

   assign req.valid = out_valid_q;
   assign req.addr = addr_q;
   assign req.dev_addr = dev_addr_q;
   assign req.we = we_q;
   assign over_limit_o = over_limit_q;

   // host DRAM never sees traffic unless software has allocated it
   a_no_xfer_unallocated: assert property (
      @(posedge aclk_i) disable iff (!arst_n_i)
      req.valid && req.ready |-> dram_alloc_i
   );

endmodule

`default_nettype wire

//--- mem_profiler.sv
`timescale 1ns/1ps
`default_nettype none

module mem_profiler (
   input wire aclk_i,
   input wire arst_n_i,
   input wire dev_reset_i,
   mem_req_if.monitor mon,
   output logic [zynq_bridge_pkg::PROFILE_REGIONS-1:0] profile_o,
   output logic [zynq_bridge_pkg::DATA_W-1:0] req_count_o
);
   import zynq_bridge_pkg::*;

   logic [PROFILE_REGIONS-1:0] profile_q;
   logic [DATA_W-1:0] count_q;
   logic [PROFILE_IDX_W-1:0] region;
   logic xfer;

   // a request counts only on the cycle it actually transfers
   assign xfer = mon.valid & mon.ready;

   // region index comes from the device address, not the remapped one,
   // so the bitmap shows the device view of memory use
   assign region = mon.dev_addr[PROFILE_LSB +: PROFILE_IDX_W];

   // bitmap only ever gains bits until the next run starts
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         profile_q <= '0;
         count_q <= '0;
      end
      else if (dev_reset_i)
      begin
         profile_q <= '0;
         count_q <= '0;
      end
      else if (xfer)
      begin
         profile_q[region] <= 1'b1;
         count_q <= count_q + 1'b1;
      end
   end

   assign profile_o = profile_q;
   assign req_count_o = count_q;

endmodule

`default_nettype wire

//--- zynq_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module zynq_bridge_top (
   input wire aclk_i,
   input wire arst_n_i,
   // register port from the shell
   input wire csr_we_i,
   input wire zynq_bridge_pkg::csr_addr_t csr_waddr_i,
   input wire [zynq_bridge_pkg::DATA_W-1:0] csr_wdata_i,
   input wire csr_re_i,
   input wire zynq_bridge_pkg::csr_addr_t csr_raddr_i,
   output logic [zynq_bridge_pkg::DATA_W-1:0] csr_rdata_o,
   output logic csr_rvalid_o,
   // host writes through the second slave port
   input wire host_wr_valid_i,
   output logic host_wr_ready_o,
   input wire [zynq_bridge_pkg::ADDR_W-1:0] host_wr_addr_i,
   input wire [zynq_bridge_pkg::DATA_W-1:0] host_wr_data_i,
   input wire [zynq_bridge_pkg::STRB_W-1:0] host_wr_strb_i,
   output logic dev_wr_valid_o,
   input wire dev_wr_ready_i,
   output logic [zynq_bridge_pkg::ADDR_W-1:0] dev_wr_addr_o,
   output logic [zynq_bridge_pkg::DATA_W-1:0] dev_wr_data_o,
   output logic [zynq_bridge_pkg::STRB_W-1:0] dev_wr_strb_o,
   // host reads through the second slave port
   input wire host_rd_valid_i,
   output logic host_rd_ready_o,
   input wire [zynq_bridge_pkg::ADDR_W-1:0] host_rd_addr_i,
   output logic dev_rd_valid_o,
   input wire dev_rd_ready_i,
   output logic [zynq_bridge_pkg::ADDR_W-1:0] dev_rd_addr_o,
   // device memory requests and their remapped form
   input wire mem_req_valid_i,
   output logic mem_req_ready_o,
   input wire [zynq_bridge_pkg::ADDR_W-1:0] mem_req_addr_i,
   input wire mem_req_we_i,
   output logic dram_valid_o,
   input wire dram_ready_i,
   output logic [zynq_bridge_pkg::ADDR_W-1:0] dram_addr_o,
   output logic dram_we_o,
   output logic dev_reset_o
);
   import zynq_bridge_pkg::*;

   host_wr_req_t host_wr_req;
   host_wr_req_t dev_wr_req;
   host_rd_req_t host_rd_req;
   host_rd_req_t dev_rd_req;
   logic [ADDR_W-1:0] dram_base;
   logic dram_alloc;
   logic dev_reset;
   logic over_limit;
   logic [PROFILE_REGIONS-1:0] profile;
   logic [DATA_W-1:0] req_count;

   mem_req_if dram_req ();

   csr_regs u_csr_regs (
      .aclk_i(aclk_i),
      .arst_n_i(arst_n_i),
      .csr_we_i(csr_we_i),
      .csr_waddr_i(csr_waddr_i),
      .csr_wdata_i(csr_wdata_i),
      .csr_re_i(csr_re_i),
      .csr_raddr_i(csr_raddr_i),
      .csr_rdata_o(csr_rdata_o),
      .csr_rvalid_o(csr_rvalid_o),
      .over_limit_i(over_limit),
      .profile_i(profile),
      .req_count_i(req_count),
      .dram_base_o(dram_base),
      .dram_alloc_o(dram_alloc),
      .dev_reset_o(dev_reset)
   );

   // host write path, data and strobes ride along untouched
   assign host_wr_req = '{addr: host_wr_addr_i, data: host_wr_data_i, strb: host_wr_strb_i};

   host_addr_xlate #(.req_t(host_wr_req_t)) u_wr_xlate (
      .aclk_i(aclk_i),
      .arst_n_i(arst_n_i),
      .in_valid_i(host_wr_valid_i),
      .in_ready_o(host_wr_ready_o),
      .in_req_i(host_wr_req),
      .out_valid_o(dev_wr_valid_o),
      .out_ready_i(dev_wr_ready_i),
      .out_req_o(dev_wr_req)
   );

   assign dev_wr_addr_o = dev_wr_req.addr;
   assign dev_wr_data_o = dev_wr_req.data;
   assign dev_wr_strb_o = dev_wr_req.strb;

   // host read path shares the same stage with an address-only payload
   assign host_rd_req = '{addr: host_rd_addr_i};

   host_addr_xlate #(.req_t(host_rd_req_t)) u_rd_xlate (
      .aclk_i(aclk_i),
      .arst_n_i(arst_n_i),
      .in_valid_i(host_rd_valid_i),
      .in_ready_o(host_rd_ready_o),
      .in_req_i(host_rd_req),
      .out_valid_o(dev_rd_valid_o),
      .out_ready_i(dev_rd_ready_i),
      .out_req_o(dev_rd_req)
   );

   assign dev_rd_addr_o = dev_rd_req.addr;

   // device DRAM traffic is remapped and watched by the profiler
   dram_remap u_dram_remap (
      .aclk_i(aclk_i),
      .arst_n_i(arst_n_i),
      .dev_reset_i(dev_reset),
      .dram_alloc_i(dram_alloc),
      .dram_base_i(dram_base),
      .in_valid_i(mem_req_valid_i),
      .in_ready_o(mem_req_ready_o),
      .in_addr_i(mem_req_addr_i),
      .in_we_i(mem_req_we_i),
      .req(dram_req.source),
      .over_limit_o(over_limit)
   );

   mem_profiler u_mem_profiler (
      .aclk_i(aclk_i),
      .arst_n_i(arst_n_i),
      .dev_reset_i(dev_reset),
      .mon(dram_req.monitor),
      .profile_o(profile),
      .req_count_o(req_count)
   );

   assign dram_req.ready = dram_ready_i;
   assign dram_valid_o = dram_req.valid;
   assign dram_addr_o = dram_req.addr;
   assign dram_we_o = dram_req.we;
   assign dev_reset_o = dev_reset;

endmodule

`default_nettype wire

//--- zynq_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module zynq_bridge_tb;
   import zynq_bridge_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int DRIVE_DELAY = 10;
   // rough length of all tests in clock cycles, the watchdog allows twice that
   localparam int STIM_CYCLES = 300;
   // longest wait for any single handshake or drain
   localparam int HS_LIMIT = 20;

   logic aclk;
   logic arst_n;
   logic csr_we;
   csr_addr_t csr_waddr;
   logic [DATA_W-1:0] csr_wdata;
   logic csr_re;
   csr_addr_t csr_raddr;
   logic [DATA_W-1:0] csr_rdata;
   logic csr_rvalid;
   logic host_wr_valid;
   logic host_wr_ready;
   logic [ADDR_W-1:0] host_wr_addr;
   logic [DATA_W-1:0] host_wr_data;
   logic [STRB_W-1:0] host_wr_strb;
   logic dev_wr_valid;
   logic dev_wr_ready;
   logic [ADDR_W-1:0] dev_wr_addr;
   logic [DATA_W-1:0] dev_wr_data;
   logic [STRB_W-1:0] dev_wr_strb;
   logic host_rd_valid;
   logic host_rd_ready;
   logic [ADDR_W-1:0] host_rd_addr;
   logic dev_rd_valid;
   logic dev_rd_ready;
   logic [ADDR_W-1:0] dev_rd_addr;
   logic mem_valid;
   logic mem_ready;
   logic [ADDR_W-1:0] mem_addr;
   logic mem_we;
   logic dram_valid;
   logic dram_ready;
   logic [ADDR_W-1:0] dram_addr;
   logic dram_we;
   logic dev_reset;

   int value_errors;
   int hs_errors;
   integer seed;
   // base that software last wrote, used to predict remapped addresses
   logic [ADDR_W-1:0] cur_base;

   // expected outputs in order, popped by the monitors below
   host_wr_req_t wr_exp_q[$];
   logic [ADDR_W-1:0] rd_exp_q[$];
   logic [ADDR_W-1:0] dram_addr_q[$];
   logic dram_we_q[$];

   zynq_bridge_top dut_i (
      .aclk_i(aclk), .arst_n_i(arst_n),
      .csr_we_i(csr_we), .csr_waddr_i(csr_waddr), .csr_wdata_i(csr_wdata),
      .csr_re_i(csr_re), .csr_raddr_i(csr_raddr),
      .csr_rdata_o(csr_rdata), .csr_rvalid_o(csr_rvalid),
      .host_wr_valid_i(host_wr_valid), .host_wr_ready_o(host_wr_ready),
      .host_wr_addr_i(host_wr_addr), .host_wr_data_i(host_wr_data),
      .host_wr_strb_i(host_wr_strb),
      .dev_wr_valid_o(dev_wr_valid), .dev_wr_ready_i(dev_wr_ready),
      .dev_wr_addr_o(dev_wr_addr), .dev_wr_data_o(dev_wr_data), .dev_wr_strb_o(dev_wr_strb),
      .host_rd_valid_i(host_rd_valid), .host_rd_ready_o(host_rd_ready),
      .host_rd_addr_i(host_rd_addr),
      .dev_rd_valid_o(dev_rd_valid), .dev_rd_ready_i(dev_rd_ready), .dev_rd_addr_o(dev_rd_addr),
      .mem_req_valid_i(mem_valid), .mem_req_ready_o(mem_ready),
      .mem_req_addr_i(mem_addr), .mem_req_we_i(mem_we),
      .dram_valid_o(dram_valid), .dram_ready_i(dram_ready),
      .dram_addr_o(dram_addr), .dram_we_o(dram_we),
      .dev_reset_o(dev_reset)
   );

   initial
   begin
      aclk = 1'b0;
      forever #(CLK_PERIOD / 2) aclk = ~aclk;
   end

   // window rule: the upper window drops bit 29, the rest is DRAM and gains bit 31
   function automatic logic [ADDR_W-1:0] window_expect(input logic [ADDR_W-1:0] a);
      if (a > 32'h2000_0000)
         return a ^ 32'h2000_0000;
      else
         return a ^ 32'h8000_0000;
   endfunction

   // DRAM offset is the device address without bit 31, rebased on the allocation
   function automatic logic [ADDR_W-1:0] dram_expect(input logic [ADDR_W-1:0] a);
      return (a & 32'h7FFF_FFFF) + cur_base;
   endfunction

   function automatic logic ready_of(input int ch);
      case (ch)
         0: return host_wr_ready;
         1: return host_rd_ready;
         default: return mem_ready;
      endcase
   endfunction

   task automatic report_counts();
      $display("errors: %0d value mismatches, %0d handshake failures", value_errors, hs_errors);
   endtask

   // move to the drive point of the next cycle
   task automatic step();
      @(posedge aclk);
      #(DRIVE_DELAY);
   endtask

   task automatic csr_write(input csr_addr_t idx, input logic [DATA_W-1:0] val);
      csr_we = 1'b1;
      csr_waddr = idx;
      csr_wdata = val;
      step();
      csr_we = 1'b0;
   endtask

   // one-cycle read latency, so the response is already there after one step
   task automatic check_csr(input csr_addr_t idx, input logic [DATA_W-1:0] exp,
                            input string what);
      csr_re = 1'b1;
      csr_raddr = idx;
      step();
      csr_re = 1'b0;
      if (!csr_rvalid)
      begin
         hs_errors++;
         $display("read of %s got no response from the DUT", what);
      end
      else
         assert (csr_rdata === exp)
         else
         begin
            value_errors++;
            $display("Error at %0t ns: %s reads %h, expected %h", $time, what, csr_rdata, exp);
         end
   endtask

   // ready is looked at mid-cycle where it is stable, the transfer is on the next edge
   task automatic wait_accept(input int ch, input string what);
      int n;
      n = 0;
      @(negedge aclk);
      while (!ready_of(ch) && n < HS_LIMIT)
      begin
         @(negedge aclk);
         n++;
      end
      if (!ready_of(ch))
      begin
         hs_errors++;
         $display("%s request was never accepted by the DUT", what);
      end
      step();
   endtask

   task automatic send_host_wr(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                               input logic [STRB_W-1:0] s);
      host_wr_req_t e;
      e.addr = window_expect(a);
      e.data = d;
      e.strb = s;
      wr_exp_q.push_back(e);
      host_wr_valid = 1'b1;
      host_wr_addr = a;
      host_wr_data = d;
      host_wr_strb = s;
      wait_accept(0, "host write");
      host_wr_valid = 1'b0;
   endtask

   task automatic send_host_rd(input logic [ADDR_W-1:0] a);
      rd_exp_q.push_back(window_expect(a));
      host_rd_valid = 1'b1;
      host_rd_addr = a;
      wait_accept(1, "host read");
      host_rd_valid = 1'b0;
   endtask

   task automatic send_mem(input logic [ADDR_W-1:0] a, input logic we);
      dram_addr_q.push_back(dram_expect(a));
      dram_we_q.push_back(we);
      mem_valid = 1'b1;
      mem_addr = a;
      mem_we = we;
      wait_accept(2, "device memory");
      mem_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (wr_exp_q.size() + rd_exp_q.size() + dram_addr_q.size() != 0 && n < HS_LIMIT)
      begin
         step();
         n++;
      end
      if (wr_exp_q.size() + rd_exp_q.size() + dram_addr_q.size() != 0)
      begin
         hs_errors++;
         $display("expected outputs never left the DUT");
         wr_exp_q.delete();
         rd_exp_q.delete();
         dram_addr_q.delete();
         dram_we_q.delete();
      end
   endtask

   // clearing the run bit puts the device in reset, setting it again starts a new run
   task automatic restart_device();
      csr_write(CSR_CTRL, 0);
      step();
      step();
      csr_write(CSR_CTRL, 1);
      step();
      step();
   endtask

   // monitors compare every transfer against the head of its queue
   always @(negedge aclk)
   begin : wr_monitor
      host_wr_req_t e;
      if (arst_n && dev_wr_valid && dev_wr_ready)
      begin
         if (wr_exp_q.size() == 0)
         begin
            hs_errors++;
            $display("device write left the DUT with none expected");
         end
         else
         begin
            e = wr_exp_q.pop_front();
            assert (dev_wr_addr === e.addr && dev_wr_data === e.data && dev_wr_strb === e.strb)
            else
            begin
               value_errors++;
               $display("Error at %0t ns: device write %h/%h/%h, expected %h/%h/%h", $time,
                        dev_wr_addr, dev_wr_data, dev_wr_strb, e.addr, e.data, e.strb);
            end
         end
      end
   end

   always @(negedge aclk)
   begin : rd_monitor
      logic [ADDR_W-1:0] e;
      if (arst_n && dev_rd_valid && dev_rd_ready)
      begin
         if (rd_exp_q.size() == 0)
         begin
            hs_errors++;
            $display("device read left the DUT with none expected");
         end
         else
         begin
            e = rd_exp_q.pop_front();
            assert (dev_rd_addr === e)
            else
            begin
               value_errors++;
               $display("Error at %0t ns: device read %h, expected %h", $time, dev_rd_addr, e);
            end
         end
      end
   end

   always @(negedge aclk)
   begin : dram_monitor
      logic [ADDR_W-1:0] ea;
      logic ew;
      if (arst_n && dram_valid && dram_ready)
      begin
         if (dram_addr_q.size() == 0)
         begin
            hs_errors++;
            $display("DRAM request left the DUT with none expected");
         end
         else
         begin
            ea = dram_addr_q.pop_front();
            ew = dram_we_q.pop_front();
            assert (dram_addr === ea && dram_we === ew)
            else
            begin
               value_errors++;
               $display("Error at %0t ns: DRAM request %h we %b, expected %h we %b", $time,
                        dram_addr, dram_we, ea, ew);
            end
         end
      end
   end

   task automatic test_reset();
      int k;
      assert (!dev_wr_valid && !dev_rd_valid && !dram_valid && !csr_rvalid && dev_reset)
      else
      begin
         value_errors++;
         $display("Error at %0t ns: outputs after reset are not idle", $time);
      end
      for (k = 0; k <= 8; k++)
         check_csr(csr_addr_t'(k), '0, $sformatf("CSR %0d after reset", k));
      csr_write(CSR_CTRL, 1);
      step();
      assert (!dev_reset)
      else
      begin
         value_errors++;
         $display("Error at %0t ns: device reset still high after run bit set", $time);
      end
   endtask

   task automatic test_host_window();
      int i;
      logic [ADDR_W-1:0] a;
      host_wr_req_t held;
      // even items hit the DRAM window, odd ones the device-local window
      for (i = 0; i < 8; i++)
      begin
         a = $random(seed);
         if (i % 2 == 0)
            a = a & 32'h1FFF_FFFF;
         else
            a = a | 32'h4000_0000;
         send_host_wr(a, $random(seed), STRB_W'($random(seed)));
         send_host_rd(a ^ 32'h0000_0ff0);
      end
      // the split address itself still belongs to DRAM
      send_host_rd(HOST_WINDOW_SPLIT);
      send_host_rd(HOST_WINDOW_SPLIT + 4);
      wait_drain();
      // stall the device side with one item out and a second one waiting
      dev_wr_ready = 1'b0;
      send_host_wr(32'h3000_0010, 32'hA5A5_0001, 4'hF);
      held = wr_exp_q[0];
      fork
         send_host_wr(32'h0000_0020, 32'hA5A5_0002, 4'h3);
         begin
            repeat (4)
            begin
               @(negedge aclk);
               assert (dev_wr_valid && dev_wr_addr === held.addr &&
                       dev_wr_data === held.data && dev_wr_strb === held.strb &&
                       !host_wr_ready)
               else
               begin
                  value_errors++;
                  $display("Error at %0t ns: stalled device write did not hold", $time);
               end
            end
            step();
            dev_wr_ready = 1'b1;
         end
      join
      wait_drain();
   endtask

   task automatic test_dram_remap();
      int i;
      // gate stays shut while the allocation flag is clear
      mem_valid = 1'b1;
      mem_addr = 32'h8000_1000;
      repeat (5)
      begin
         @(negedge aclk);
         assert (!mem_ready)
         else
         begin
            value_errors++;
            $display("Error at %0t ns: memory request accepted without allocation", $time);
         end
      end
      step();
      mem_valid = 1'b0;
      cur_base = 32'h1000_0000;
      csr_write(CSR_DRAM_BASE, cur_base);
      csr_write(CSR_DRAM_ALLOC, 1);
      for (i = 0; i < 8; i++)
         send_mem($random(seed) | 32'h8000_0000, i[0]);
      wait_drain();
      // held request keeps its payload while the DRAM side stalls
      dram_ready = 1'b0;
      send_mem(32'h8000_2040, 1'b1);
      repeat (4)
      begin
         @(negedge aclk);
         assert (dram_valid && dram_addr === dram_addr_q[0] && dram_we && !mem_ready)
         else
         begin
            value_errors++;
            $display("Error at %0t ns: stalled DRAM request did not hold", $time);
         end
      end
      step();
      dram_ready = 1'b1;
      wait_drain();
   endtask

   task automatic test_over_limit();
      // earlier random traffic may have set the flag already
      csr_write(CSR_STATUS, 1);
      check_csr(CSR_STATUS, 0, "status after clear");
      send_mem(32'h8000_0000 + MEM_UPPER_LIMIT - 32'h40, 1'b0);
      wait_drain();
      step();
      check_csr(CSR_STATUS, 0, "status below limit");
      send_mem(32'h8000_0000 + MEM_UPPER_LIMIT, 1'b0);
      wait_drain();
      step();
      check_csr(CSR_STATUS, 1, "status at limit");
      csr_write(CSR_STATUS, 1);
      check_csr(CSR_STATUS, 0, "status after second clear");
   endtask

   task automatic test_profiler();
      int i;
      int k;
      logic [ADDR_W-1:0] a;
      logic [PROFILE_REGIONS-1:0] exp_profile;
      // a new run starts with an empty bitmap and a zero count
      restart_device();
      exp_profile = '0;
      for (i = 0; i < 12; i++)
      begin
         a = $random(seed) | 32'h8000_0000;
         exp_profile[(a >> 23) & 7'h7F] = 1'b1;
         send_mem(a, i[1]);
      end
      wait_drain();
      step();
      check_csr(CSR_REQ_COUNT, 12, "request count");
      for (k = 0; k < 4; k++)
         check_csr(csr_addr_t'(CSR_PROFILE0 + k), exp_profile[k*DATA_W +: DATA_W],
                   $sformatf("profile word %0d", k));
      restart_device();
      check_csr(CSR_REQ_COUNT, 0, "request count after restart");
      for (k = 0; k < 4; k++)
         check_csr(csr_addr_t'(CSR_PROFILE0 + k), '0,
                   $sformatf("profile word %0d after restart", k));
   endtask

   initial
   begin
      #(STIM_CYCLES * 2 * CLK_PERIOD);
      $display("watchdog expired, the tests did not finish in time");
      report_counts();
      $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      value_errors = 0;
      hs_errors = 0;
      seed = 19;
      cur_base = '0;
      arst_n = 1'b0;
      csr_we = 1'b0;
      csr_waddr = '0;
      csr_wdata = '0;
      csr_re = 1'b0;
      csr_raddr = '0;
      host_wr_valid = 1'b0;
      host_wr_addr = '0;
      host_wr_data = '0;
      host_wr_strb = '0;
      dev_wr_ready = 1'b1;
      host_rd_valid = 1'b0;
      host_rd_addr = '0;
      dev_rd_ready = 1'b1;
      mem_valid = 1'b0;
      mem_addr = '0;
      mem_we = 1'b0;
      dram_ready = 1'b1;
      repeat (5) @(posedge aclk);
      #(DRIVE_DELAY);
      arst_n = 1'b1;
      step();
      test_reset();
      test_host_window();
      test_dram_remap();
      test_over_limit();
      test_profiler();
      report_counts();
      if (value_errors == 0 && hs_errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- zynq_bridge.f
zynq_bridge_pkg.sv
mem_req_if.sv
csr_regs.sv
host_addr_xlate.sv
dram_remap.sv
mem_profiler.sv
zynq_bridge_top.sv
zynq_bridge_tb.sv

//--- Bender.yml
package:
  name: zynq_bridge

sources:
  - zynq_bridge_pkg.sv
  - mem_req_if.sv
  - csr_regs.sv
  - host_addr_xlate.sv
  - dram_remap.sv
  - mem_profiler.sv
  - zynq_bridge_top.sv
  - target: simulation
    files:
      - zynq_bridge_tb.sv
